//--- hdl/dmem_defs.svh
`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

// Data memory bus geometry
`define DMEM_ADDR_W 32              // Byte address width
`define DMEM_DATA_W 32              // Bus word width
`define DMEM_STRB_W 4               // One strobe per byte lane

// Memory mapped IO window
// An address hits MMIO when (addr & ~MMIO_MASK) == MMIO_BASE
`define MMIO_BASE 32'h0001_0000     // Window base
`define MMIO_MASK 32'h0000_FFFF     // Offset bits inside window

// MMIO register offsets
`define MMIO_OFF_SCRATCH0 32'h0000_0000 // Scratch register 0
`define MMIO_OFF_SCRATCH1 32'h0000_0004 // Scratch register 1
`define MMIO_OFF_SUM      32'h0000_0008 // Read-only sum

`endif

//--- hdl/dmem_pkg.sv
`include "dmem_defs.svh"

package dmem_pkg;

    typedef logic [`DMEM_ADDR_W-1:0] mem_addr_t;  // Byte address
    typedef logic [`DMEM_DATA_W-1:0] mem_data_t;  // Bus data word
    typedef logic [`DMEM_STRB_W-1:0] mem_strb_t;  // Byte lane strobes

    // Access size as issued by the core
    typedef enum logic [1:0] {
        lsu_byte = 2'd0,
        lsu_half = 2'd1,
        lsu_word = 2'd2
    } lsu_size_e;

    typedef struct packed {
        logic      wen;                 // Store when set
        lsu_size_e size;                // Access width
        logic      sign;                // Sign-extend loads
        mem_addr_t addr;                // Unaligned byte address
        mem_data_t wdata;               // Store data, low bits used
    } core_req_t;

    typedef struct packed {
        logic      err;                 // Bus or alignment error
        mem_data_t rdata;               // Extended load data
    } core_rsp_t;

    typedef struct packed {
        mem_addr_t addr;                // Word aligned address
        logic      wen;                 // Write enable
        mem_strb_t strb;                // Active byte lanes
        mem_data_t wdata;               // Lane replicated data
    } bus_req_t;

    typedef struct packed {
        logic      err;                 // Slave error
        mem_data_t rdata;               // Raw word
    } bus_rsp_t;

    // Attributes held for one cycle between grant and response
    typedef struct packed {
        logic [1:0] offset;             // Byte offset in word
        lsu_size_e  size;               // Access width
        logic       sign;               // Sign-extend loads
        logic       wen;                // Store, so no load data
        logic       misaligned;         // Never went to the bus
    } load_info_t;

endpackage

//--- hdl/lsu_request.sv
`timescale 1ns/1ps
`include "dmem_defs.svh"

module lsu_request import dmem_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       core_req_valid,  // Core has a request
    input  core_req_t  core_req,        // Held until core_gnt
    output logic       core_gnt,        // Transfer accepted
    output logic       bus_req_valid,   // Aligned request to bus
    output bus_req_t   bus_req,
    input  logic       bus_gnt,         // Bus accepted request
    output load_info_t load_info,       // Attributes for stage 3
    output logic       rsp_valid        // Response due this cycle
);

    logic [1:0] offset;
    logic       misaligned;
    logic       grant;
    mem_data_t  wdata_lanes;
    mem_strb_t  strb;

    assign offset = core_req.addr[1:0];

    // Lane replication, strobes and alignment check per size
    always_comb begin
        unique case (core_req.size)
            lsu_byte: begin
                wdata_lanes = {4{core_req.wdata[7:0]}};
                strb        = mem_strb_t'(4'b0001) << offset;
                misaligned  = 1'b0;                 // Bytes always fit
            end
            lsu_half: begin
                wdata_lanes = {2{core_req.wdata[15:0]}};
                strb        = mem_strb_t'(4'b0011) << offset;
                misaligned  = offset[0];            // Odd address
            end
            lsu_word: begin
                wdata_lanes = core_req.wdata;
                strb        = 4'b1111;
                misaligned  = |offset;              // Not a multiple of 4
            end
            default: begin
                wdata_lanes = core_req.wdata;
                strb        = 4'b0000;
                misaligned  = 1'b1;                 // Illegal size rejected
            end
        endcase
    end

    // Misaligned requests stay off the bus and are granted here
    assign bus_req_valid = core_req_valid && !misaligned;
    assign core_gnt      = core_req_valid && (misaligned || bus_gnt);
    assign grant         = core_gnt;

    assign bus_req.addr  = {core_req.addr[`DMEM_ADDR_W-1:2], 2'b00}; // Word address
    assign bus_req.wen   = core_req.wen;
    assign bus_req.strb  = strb;
    assign bus_req.wdata = wdata_lanes;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= grant;                     // One response per grant
        end
    end

    always_ff @(posedge g_clk) begin
        if (grant) begin
            load_info.offset     <= offset;
            load_info.size       <= core_req.size;
            load_info.sign       <= core_req.sign;
            load_info.wen        <= core_req.wen;
            load_info.misaligned <= misaligned;
        end
    end

endmodule

//--- hdl/core_mmio_mux.sv
`timescale 1ns/1ps
`include "dmem_defs.svh"

module core_mmio_mux import dmem_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     int_req_valid,     // Request from stage 1
    input  bus_req_t int_req,
    output logic     int_gnt,           // Grant from selected side
    output bus_rsp_t int_rsp,           // Response from routed side
    output logic     ext_req_valid,     // To external memory
    output bus_req_t ext_req,
    input  logic     ext_gnt,
    input  bus_rsp_t ext_rsp,
    output logic     mmio_req_valid,    // To MMIO registers
    output bus_req_t mmio_req,
    input  logic     mmio_gnt,
    input  bus_rsp_t mmio_rsp
);

    logic mmio_hit;
    logic route_mmio;

    // Region decode on the bits above the offset mask
    assign mmio_hit = (int_req.addr & ~mem_addr_t'(`MMIO_MASK)) == mem_addr_t'(`MMIO_BASE);

    // Payload goes both ways, only one side sees valid
    assign ext_req  = int_req;
    assign mmio_req = int_req;

    assign ext_req_valid  = int_req_valid && !mmio_hit;
    assign mmio_req_valid = int_req_valid &&  mmio_hit;

    assign int_gnt = mmio_hit ? mmio_gnt : ext_gnt;

    // Remember which side owes the next response
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            route_mmio <= 1'b0;
        end else if (int_req_valid && int_gnt) begin
            route_mmio <= mmio_hit;
        end
    end

    assign int_rsp = route_mmio ? mmio_rsp : ext_rsp;

endmodule

//--- hdl/mmio_regs.sv
`timescale 1ns/1ps
`include "dmem_defs.svh"

module mmio_regs import dmem_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     req_valid,         // Access in MMIO window
    input  bus_req_t req,
    output logic     gnt,               // Always ready
    output bus_rsp_t rsp                // Valid cycle after grant
);

    mem_addr_t offset;
    mem_data_t scratch0;
    mem_data_t scratch1;
    mem_data_t sum;
    mem_data_t rdata_nxt;
    logic      err_nxt;
    logic      full_word;
    logic      wr_ok;

    assign gnt       = req_valid;                   // No wait states
    assign offset    = req.addr & mem_addr_t'(`MMIO_MASK);
    assign sum       = scratch0 + scratch1;         // Wraps modulo 2^32
    assign full_word = &req.strb;

    // Decode read data and error for the current access
    always_comb begin
        rdata_nxt = '0;
        err_nxt   = 1'b0;
        case (offset)
            `MMIO_OFF_SCRATCH0: begin
                rdata_nxt = scratch0;
                err_nxt   = req.wen && !full_word;  // Partial write refused
            end
            `MMIO_OFF_SCRATCH1: begin
                rdata_nxt = scratch1;
                err_nxt   = req.wen && !full_word;
            end
            `MMIO_OFF_SUM: begin
                rdata_nxt = sum;
                err_nxt   = req.wen;                // Read only
            end
            default: begin
                err_nxt   = 1'b1;                   // Unmapped, rdata 0
            end
        endcase
    end

    assign wr_ok = req_valid && req.wen && !err_nxt;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            scratch0 <= '0;
            scratch1 <= '0;
        end else if (wr_ok) begin
            if (offset == `MMIO_OFF_SCRATCH0) begin
                scratch0 <= req.wdata;
            end
            if (offset == `MMIO_OFF_SCRATCH1) begin
                scratch1 <= req.wdata;
            end
        end
    end

    // Response captured on grant, read before the write lands
    always_ff @(posedge g_clk) begin
        if (req_valid) begin
            rsp.err   <= err_nxt;
            rsp.rdata <= rdata_nxt;
        end
    end

endmodule

//--- hdl/lsu_response.sv
`timescale 1ns/1ps

module lsu_response import dmem_pkg::*; (
    input  logic       rsp_valid,       // Response due this cycle
    input  load_info_t load_info,       // Registered at grant
    input  bus_rsp_t   bus_rsp,         // Routed bus response
    output logic       core_rsp_valid,
    output core_rsp_t  core_rsp
);

    mem_data_t shifted;
    mem_data_t extended;
    logic      err;

    // Bring the addressed lane down to bit 0
    assign shifted = bus_rsp.rdata >> {load_info.offset, 3'b000};

    always_comb begin
        case (load_info.size)
            lsu_byte: begin
                extended = {{24{load_info.sign && shifted[7]}}, shifted[7:0]};
            end
            lsu_half: begin
                extended = {{16{load_info.sign && shifted[15]}}, shifted[15:0]};
            end
            default: begin
                extended = shifted;                 // Word, no shift applied
            end
        endcase
    end

    // Alignment fault wins over whatever the bus returned
    assign err = rsp_valid && (load_info.misaligned || bus_rsp.err);

    assign core_rsp_valid = rsp_valid;
    assign core_rsp.err   = err;
    assign core_rsp.rdata = (err || load_info.wen) ? '0 : extended; // Stores return 0

endmodule

//--- hdl/dmem_subsys_top.sv
`timescale 1ns/1ps

module dmem_subsys_top import dmem_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      core_req_valid,   // Core load or store
    input  core_req_t core_req,
    output logic      core_gnt,
    output logic      core_rsp_valid,   // Cycle after core_gnt
    output core_rsp_t core_rsp,
    output logic      ext_req_valid,    // External memory bus
    output bus_req_t  ext_req,
    input  logic      ext_gnt,
    input  bus_rsp_t  ext_rsp           // Cycle after ext_gnt
);

    logic       bus_req_valid;
    bus_req_t   bus_req;
    logic       bus_gnt;
    bus_rsp_t   bus_rsp;
    load_info_t load_info;
    logic       rsp_valid;
    logic       mmio_req_valid;
    bus_req_t   mmio_req;
    logic       mmio_gnt;
    bus_rsp_t   mmio_rsp;

    lsu_request u_lsu_request (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_gnt       (core_gnt),
        .bus_req_valid  (bus_req_valid),
        .bus_req        (bus_req),
        .bus_gnt        (bus_gnt),
        .load_info      (load_info),
        .rsp_valid      (rsp_valid)
    );

    core_mmio_mux u_core_mmio_mux (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .int_req_valid  (bus_req_valid),
        .int_req        (bus_req),
        .int_gnt        (bus_gnt),
        .int_rsp        (bus_rsp),
        .ext_req_valid  (ext_req_valid),
        .ext_req        (ext_req),
        .ext_gnt        (ext_gnt),
        .ext_rsp        (ext_rsp),
        .mmio_req_valid (mmio_req_valid),
        .mmio_req       (mmio_req),
        .mmio_gnt       (mmio_gnt),
        .mmio_rsp       (mmio_rsp)
    );

    mmio_regs u_mmio_regs (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .req_valid      (mmio_req_valid),
        .req            (mmio_req),
        .gnt            (mmio_gnt),
        .rsp            (mmio_rsp)
    );

    lsu_response u_lsu_response (
        .rsp_valid      (rsp_valid),
        .load_info      (load_info),
        .bus_rsp        (bus_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp)
    );

endmodule

//--- sim/dmem_props.sv
`timescale 1ns/1ps

module dmem_props import dmem_pkg::*; (
    input logic      g_clk,
    input logic      g_resetn,
    input logic      core_req_valid,
    input core_req_t core_req,
    input logic      core_gnt,
    input logic      core_rsp_valid,
    input logic      ext_req_valid,
    input logic      mmio_req_valid         // Internal to the top level
);

    int unsigned assert_fails = 0;          // Failures seen so far

    // Core must hold its request until granted
    a_req_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        core_req_valid && !core_gnt |=> core_req_valid && $stable(core_req))
        else begin
            assert_fails++;
            $error("core_req changed or dropped before core_gnt");
        end

    // Every grant gives a response next cycle
    a_rsp_after_gnt: assert property (@(posedge g_clk) disable iff (!g_resetn)
        core_req_valid && core_gnt |=> core_rsp_valid)
        else begin
            assert_fails++;
            $error("no core_rsp_valid in the cycle after a grant");
        end

    // And nothing else does
    a_no_spurious_rsp: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(core_req_valid && core_gnt) |=> !core_rsp_valid)
        else begin
            assert_fails++;
            $error("core_rsp_valid without a grant in the previous cycle");
        end

    a_one_side: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(ext_req_valid && mmio_req_valid))
        else begin
            assert_fails++;
            $error("ext_req_valid and mmio_req_valid high together");
        end

endmodule

bind dmem_subsys_top dmem_props u_dmem_props (
    .g_clk          (g_clk),
    .g_resetn       (g_resetn),
    .core_req_valid (core_req_valid),
    .core_req       (core_req),
    .core_gnt       (core_gnt),
    .core_rsp_valid (core_rsp_valid),
    .ext_req_valid  (ext_req_valid),
    .mmio_req_valid (mmio_req_valid)
);

//--- sim/tb_dmem_subsys.sv
`timescale 1ns/1ps
`include "dmem_defs.svh"

module tb_dmem_subsys import dmem_pkg::*; ();

    localparam int MAX_PATTERNS = 64;
    localparam int FIELDS       = 7;                // Columns per access line

    logic        g_clk;
    logic        g_resetn;
    logic        core_req_valid;
    core_req_t   core_req;
    logic        core_gnt;
    logic        core_rsp_valid;
    core_rsp_t   core_rsp;
    logic        ext_req_valid;
    bus_req_t    ext_req;
    logic        ext_gnt;
    bus_rsp_t    ext_rsp;

    mem_data_t   pat_mem [0:MAX_PATTERNS*FIELDS-1]; // Flat, FIELDS words per access
    mem_data_t   ext_mem [0:255];                   // External data memory
    int          pat_count;
    int          cur_pat;
    int          checks_failed;
    logic        patterns_loaded;
    logic [31:0] lcg_state;
    logic        pend_valid;                        // Ext transfer this cycle
    bus_req_t    pend_req;

    dmem_subsys_top DUT (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_gnt       (core_gnt),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .ext_req_valid  (ext_req_valid),
        .ext_req        (ext_req),
        .ext_gnt        (ext_gnt),
        .ext_rsp        (ext_rsp)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;                 // 20 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Above the window base but not claimed by MMIO
    function automatic logic ext_addr_err(input mem_addr_t addr);
        return (addr >= `MMIO_BASE) && ((addr & ~`MMIO_MASK) != `MMIO_BASE);
    endfunction

    // Misaligned and MMIO accesses never wait, external ones wait for ext_gnt
    function automatic logic grant_expected(input core_req_t req, input logic ext_ready);
        logic odd_half;
        logic odd_word;
        logic in_mmio;
        odd_half = (req.size == lsu_half) && req.addr[0];
        odd_word = (req.size == lsu_word) && (req.addr[1:0] != 2'b00);
        in_mmio  = (req.addr & ~`MMIO_MASK) == `MMIO_BASE;
        return odd_half || odd_word || in_mmio || ext_ready;
    endfunction

    // Sample the handshake mid-cycle, inputs settled by then
    always @(negedge g_clk) begin
        pend_valid = g_resetn && ext_req_valid && ext_gnt;
        pend_req   = ext_req;
    end

    // Response one cycle after grant, then a fresh random grant
    always @(posedge g_clk) begin
        #1;
        if (pend_valid) begin
            ext_rsp.rdata = ext_mem[pend_req.addr[9:2]];   // Read before write
            ext_rsp.err   = ext_addr_err(pend_req.addr);
            if (pend_req.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (pend_req.strb[b]) begin
                        ext_mem[pend_req.addr[9:2]][8*b +: 8] = pend_req.wdata[8*b +: 8];
                    end
                end
            end
        end else begin
            ext_rsp = '0;
        end
        lcg_state = lcg_next(lcg_state);
        ext_gnt   = (lcg_state[17:16] != 2'b00);        // Stall about one in four
    end

    // Bound assertions count their failures
    always @(negedge g_clk) begin
        if (DUT.u_dmem_props.assert_fails != 0) begin
            $display("A bound assertion failed, see the $error output above");
            $display("FAIL: see errors above");
            $fatal(1, "Assertion failed");
        end
    end

    task automatic check_data(input string name, input mem_data_t got, input mem_data_t exp);
        if (got !== exp) begin
            checks_failed++;
            $display("mismatch at %0t: %s got %h expected %h (pattern %0d)",
                     $time, name, got, exp, cur_pat);
            $display("FAIL: see errors above");
            $fatal(1, "Data compare failed");
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            checks_failed++;
            $display("mismatch at %0t: %s got %b expected %b (pattern %0d)",
                     $time, name, got, exp, cur_pat);
            $display("FAIL: see errors above");
            $fatal(1, "Error flag compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            checks_failed++;
            $display("mismatch at %0t: %s got %b expected %b (pattern %0d)",
                     $time, name, got, exp, cur_pat);
            $display("FAIL: see errors above");
            $fatal(1, "Handshake compare failed");
        end
    endtask

    task automatic load_patterns();
        mem_data_t op;
        begin
            $readmemh("sim/dmem_patterns.txt", pat_mem);
            pat_count = 0;
            op        = pat_mem[0];
            while (pat_count < MAX_PATTERNS && (op === 32'd0 || op === 32'd1)) begin
                pat_count++;
                if (pat_count < MAX_PATTERNS) begin
                    op = pat_mem[pat_count*FIELDS];
                end
            end
            if (pat_count == 0) begin
                $display("No access lines could be read from sim/dmem_patterns.txt");
                $display("FAIL: see errors above");
                $fatal(1, "Pattern file missing or empty");
            end
            patterns_loaded = 1'b1;
        end
    endtask

    task automatic drive_request(input int idx);
        int base;
        begin
            base           = idx * FIELDS;
            core_req_valid = 1'b1;
            core_req.wen   = pat_mem[base][0];
            core_req.size  = lsu_size_e'(pat_mem[base+1][1:0]);
            core_req.sign  = pat_mem[base+2][0];
            core_req.addr  = pat_mem[base+3];
            core_req.wdata = pat_mem[base+4];
        end
    endtask

    task automatic check_response(input int idx);
        int base;
        begin
            base    = idx * FIELDS;
            cur_pat = idx;
            check_flag("core_rsp_valid", core_rsp_valid, 1'b1);
            check_err("core_rsp.err", core_rsp.err, pat_mem[base+6][0]);
            check_data("core_rsp.rdata", core_rsp.rdata, pat_mem[base+5]);
        end
    endtask

    // Next request goes out in the response cycle of the previous one
    task automatic run_patterns();
        begin
            @(posedge g_clk);
            #1;
            drive_request(0);
            @(negedge g_clk);
            for (int i = 0; i < pat_count; i++) begin
                cur_pat = i;
                check_flag("core_gnt", core_gnt, grant_expected(core_req, ext_gnt));
                while (core_gnt !== 1'b1) begin
                    @(negedge g_clk);               // Held until granted
                    check_flag("core_gnt", core_gnt, grant_expected(core_req, ext_gnt));
                end
                @(posedge g_clk);
                #1;
                if (i + 1 < pat_count) begin
                    drive_request(i + 1);
                end else begin
                    core_req_valid = 1'b0;
                end
                @(negedge g_clk);
                check_response(i);
            end
        end
    endtask

    initial begin
        wait (patterns_loaded === 1'b1);
        repeat (pat_count * 16 + 50) @(posedge g_clk);
        $display("Timeout: %0d accesses did not complete within %0d cycles",
                 pat_count, pat_count * 16 + 50);
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        core_req_valid  = 1'b0;
        core_req        = '0;
        ext_gnt         = 1'b0;
        ext_rsp         = '0;
        pend_valid      = 1'b0;
        pend_req        = '0;
        lcg_state       = 32'd41;                   // Seed
        checks_failed   = 0;
        cur_pat         = 0;
        patterns_loaded = 1'b0;
        g_resetn        = 1'b0;
        for (int w = 0; w < 256; w++) begin
            ext_mem[w] = '0;
        end
        load_patterns();
        repeat (5) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        run_patterns();
        @(posedge g_clk);
        @(negedge g_clk);
        #1;
        if (checks_failed == 0 && DUT.u_dmem_props.assert_fails == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "Checks failed");
        end
    end

endmodule

//--- sim/dmem_patterns.txt
// op(1=store) size(0=byte,1=half,2=word) sign addr wdata exp_rdata exp_err
// All columns hex, one access per line
1 2 0 00000100 deadbeef 00000000 0
0 2 0 00000100 00000000 deadbeef 0
1 0 0 00000100 00000011 00000000 0
1 0 0 00000105 00000085 00000000 0
1 1 0 00000106 00008001 00000000 0
0 2 0 00000104 00000000 80018500 0
0 0 1 00000105 00000000 ffffff85 0
0 0 0 00000105 00000000 00000085 0
0 1 1 00000106 00000000 ffff8001 0
0 2 0 00000100 00000000 deadbe11 0
1 1 0 00000105 0000ffff 00000000 1
1 2 0 00000106 12345678 00000000 1
0 2 0 00000102 00000000 00000000 1
0 2 0 00000104 00000000 80018500 0
1 2 0 00010000 fffffff0 00000000 0
1 2 0 00010004 00000025 00000000 0
0 2 0 00010000 00000000 fffffff0 0
0 2 0 00010004 00000000 00000025 0
0 2 0 00010008 00000000 00000015 0
1 2 0 00010008 11111111 00000000 1
1 0 0 00010000 000000aa 00000000 1
0 2 0 0001000c 00000000 00000000 1
0 2 0 00010008 00000000 00000015 0
0 2 0 00000100 00000000 deadbe11 0
0 2 0 00010004 00000000 00000025 0
0 1 0 00000106 00000000 00008001 0
0 2 0 00010000 00000000 fffffff0 0
0 0 1 00000107 00000000 ffffff80 0

//--- build.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/lsu_request.sv
hdl/core_mmio_mux.sv
hdl/mmio_regs.sv
hdl/lsu_response.sv
hdl/dmem_subsys_top.sv
sim/dmem_props.sv
sim/tb_dmem_subsys.sv

//--- Bender.yml
package:
  name: dmem_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dmem_pkg.sv
      - hdl/lsu_request.sv
      - hdl/core_mmio_mux.sv
      - hdl/mmio_regs.sv
      - hdl/lsu_response.sv
      - hdl/dmem_subsys_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/dmem_props.sv
      - sim/tb_dmem_subsys.sv
